/* src/cdc_pkg.sv */
package cdc_pkg;

    // Data path widths
    localparam int byte_w = 8;
    localparam int word_w = 32;
    localparam int addr_w = 4;

    // APB register map
    localparam logic [addr_w-1:0] reg_data   = 4'h0;
    localparam logic [addr_w-1:0] reg_status = 4'h4;

    // Wide enough for any pointer width used here
    // Narrower Gray values are zero-extended before the call
    function automatic logic [31:0] gray_to_bin(input logic [31:0] gray);
        logic [31:0] bin;
        bin[31] = gray[31];
        for (int i = 30; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* src/gray_sync.sv */
`timescale 1ns/1ns

module gray_sync #(
    parameter int WIDTH = 5
) (
    input  logic             dst_clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] gray_in,
    output logic [WIDTH-1:0] gray_out
);
    logic [WIDTH-1:0] stage1;

    // Only one bit changes per step, so a late sample is off by one at most
    always_ff @(posedge dst_clk or posedge rst) begin
        if (rst) begin
            stage1   <= '0;
            gray_out <= '0;
        end else begin
            stage1   <= gray_in;
            gray_out <= stage1;
        end
    end

endmodule

/* src/async_fifo.sv */
`timescale 1ns/1ns

module async_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                       wr_clk,
    input  logic                       rd_clk,
    input  logic                       rd_reset,
    input  logic                       push,
    input  logic [cdc_pkg::byte_w-1:0] push_data,
    output logic                       full,
    output logic [$clog2(DEPTH):0]     wr_level,
    input  logic                       pop,
    output logic [cdc_pkg::byte_w-1:0] pop_data,
    output logic                       empty
);
    import cdc_pkg::*;

    localparam int addr_bits = $clog2(DEPTH);
    localparam int ptr_bits  = addr_bits + 1;

    logic [byte_w-1:0]   mem [DEPTH];
    logic [ptr_bits-1:0] wr_bin;
    logic [ptr_bits-1:0] wr_bin_next;
    logic [ptr_bits-1:0] wr_gray;
    logic [ptr_bits-1:0] rd_bin;
    logic [ptr_bits-1:0] rd_bin_next;
    logic [ptr_bits-1:0] rd_gray;
    logic [ptr_bits-1:0] rd_gray_wr;
    logic [ptr_bits-1:0] wr_gray_rd;
    logic [ptr_bits-1:0] rd_bin_wr;
    logic                push_ok;
    logic                pop_ok;

    // Write side
    assign push_ok     = push && !full;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge wr_clk or posedge rd_reset) begin
        if (rd_reset) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (push_ok) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push_ok) begin
            mem[wr_bin[addr_bits-1:0]] <= push_data;
        end
    end

    // Read pointer into the write domain
    gray_sync #(.WIDTH(ptr_bits)) u_rd2wr_sync (
        .dst_clk  (wr_clk),
        .rst      (rd_reset),
        .gray_in  (rd_gray),
        .gray_out (rd_gray_wr)
    );

    // Full when the pointers differ by exactly one lap
    assign full = (rd_gray_wr ==
                   {~wr_gray[ptr_bits-1:ptr_bits-2], wr_gray[ptr_bits-3:0]});

    // Level wraps modulo 2*DEPTH through the pointer width
    assign rd_bin_wr = ptr_bits'(gray_to_bin(32'(rd_gray_wr)));
    assign wr_level  = wr_bin - rd_bin_wr;

    // Read side
    assign pop_ok      = pop && !empty;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge rd_clk or posedge rd_reset) begin
        if (rd_reset) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (pop_ok) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    // Head entry, valid while not empty
    assign pop_data = mem[rd_bin[addr_bits-1:0]];

    // Write pointer into the read domain
    gray_sync #(.WIDTH(ptr_bits)) u_wr2rd_sync (
        .dst_clk  (rd_clk),
        .rst      (rd_reset),
        .gray_in  (wr_gray),
        .gray_out (wr_gray_rd)
    );

    assign empty = (wr_gray_rd == rd_gray);

endmodule

/* src/apb_fifo_port.sv */
`timescale 1ns/1ns

module apb_fifo_port #(
    parameter int DEPTH = 16
) (
    input  logic                       wr_clk,
    input  logic                       rd_reset,
    input  logic [cdc_pkg::addr_w-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [cdc_pkg::word_w-1:0] pwdata,
    output logic [cdc_pkg::word_w-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       push,
    output logic [cdc_pkg::byte_w-1:0] push_data,
    input  logic                       full,
    input  logic [$clog2(DEPTH):0]     wr_level
);
    import cdc_pkg::*;

    localparam int lvl_bits = $clog2(DEPTH) + 1;

    logic              setup;
    logic              access;
    logic              data_wr_dec;
    logic              status_rd_dec;
    logic              data_wr_q;
    logic              status_rd_q;
    logic              bad_q;
    logic [word_w-1:0] status_word;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // Only a DATA write and a STATUS read are legal
    assign data_wr_dec   = (paddr == reg_data) && pwrite;
    assign status_rd_dec = (paddr == reg_status) && !pwrite;

    // Decode taken in the setup phase and held through wait states
    always_ff @(posedge wr_clk or posedge rd_reset) begin
        if (rd_reset) begin
            data_wr_q   <= 1'b0;
            status_rd_q <= 1'b0;
            bad_q       <= 1'b0;
        end else if (setup) begin
            data_wr_q   <= data_wr_dec;
            status_rd_q <= status_rd_dec;
            bad_q       <= !(data_wr_dec || status_rd_dec);
        end
    end

    // Stall a DATA write until the FIFO has room
    assign pready = !(access && data_wr_q && full);

    // One push on the completing cycle of each DATA write
    assign push      = access && data_wr_q && !full;
    assign push_data = pwdata[byte_w-1:0];

    // STATUS layout
    always_comb begin
        status_word                = '0;
        status_word[0]             = full;
        status_word[8 +: lvl_bits] = wr_level;
    end

    assign prdata  = (access && status_rd_q) ? status_word : '0;
    assign pslverr = access && bad_q;

endmodule

/* src/word_packer.sv */
`timescale 1ns/1ns

module word_packer (
    input  logic                       rd_clk,
    input  logic                       rd_reset,
    output logic                       pop,
    input  logic [cdc_pkg::byte_w-1:0] pop_data,
    input  logic                       empty,
    output logic [cdc_pkg::word_w-1:0] word_data,
    output logic                       word_valid,
    input  logic                       word_ready
);
    import cdc_pkg::*;

    localparam int lanes     = word_w / byte_w;
    localparam int lane_bits = $clog2(lanes);
    localparam logic [lane_bits-1:0] last_lane = lane_bits'(lanes - 1);

    logic [lane_bits-1:0] lane;
    logic [word_w-1:0]    shreg;

    // No pop while a finished word waits for the consumer
    assign pop = !empty && !word_valid;

    always_ff @(posedge rd_clk or posedge rd_reset) begin
        if (rd_reset) begin
            lane       <= '0;
            word_valid <= 1'b0;
        end else begin
            if (word_valid && word_ready) begin
                word_valid <= 1'b0;
            end
            if (pop) begin
                lane <= lane + 1'b1;
                // Fourth byte closes the word
                if (lane == last_lane) begin
                    word_valid <= 1'b1;
                end
            end
        end
    end

    // New bytes enter at the top and move down
    // After four pops the first byte sits in lane 0
    always_ff @(posedge rd_clk) begin
        if (pop) begin
            shreg <= {pop_data, shreg[word_w-1:byte_w]};
        end
    end

    assign word_data = shreg;

endmodule

/* src/cdc_bridge_top.sv */
`timescale 1ns/1ns

module cdc_bridge_top #(
    parameter int DEPTH = 16
) (
    input  logic                       wr_clk,
    input  logic                       rd_clk,
    input  logic                       rd_reset,
    input  logic [cdc_pkg::addr_w-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [cdc_pkg::word_w-1:0] pwdata,
    output logic [cdc_pkg::word_w-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic [cdc_pkg::word_w-1:0] word_data,
    output logic                       word_valid,
    input  logic                       word_ready
);
    import cdc_pkg::*;

    // Write domain
    logic                  push;
    logic [byte_w-1:0]     push_data;
    logic                  full;
    logic [$clog2(DEPTH):0] wr_level;

    // Read domain
    logic                  pop;
    logic [byte_w-1:0]     pop_data;
    logic                  empty;

    apb_fifo_port #(.DEPTH(DEPTH)) u_apb_port (
        .wr_clk    (wr_clk),
        .rd_reset  (rd_reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .wr_level  (wr_level)
    );

    async_fifo #(.DEPTH(DEPTH)) u_fifo (
        .wr_clk    (wr_clk),
        .rd_clk    (rd_clk),
        .rd_reset  (rd_reset),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .wr_level  (wr_level),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    word_packer u_packer (
        .rd_clk     (rd_clk),
        .rd_reset   (rd_reset),
        .pop        (pop),
        .pop_data   (pop_data),
        .empty      (empty),
        .word_data  (word_data),
        .word_valid (word_valid),
        .word_ready (word_ready)
    );

endmodule

/* verif/tb_cdc_bridge.sv */
`timescale 1ns/1ns

module tb_cdc_bridge;
    import cdc_pkg::*;

    localparam int depth         = 16;
    localparam int lvl_bits      = $clog2(depth) + 1;
    localparam int wr_period     = 100;
    localparam int rd_half       = 65;
    // Rounded up from 1 + 200 + 20 + 25 + 7 transfers
    localparam int planned_xfers = 270;

    logic              wr_clk = 1'b0;
    logic              rd_clk = 1'b0;
    logic              rd_reset;
    logic [addr_w-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [word_w-1:0] pwdata;
    logic [word_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic [word_w-1:0] word_data;
    logic              word_valid;
    logic              word_ready;

    logic [7:0] model_q[$];
    int         ready_mode;
    int         errors;
    int         test_start_errors;
    int         tests_failed;
    int         tests_run;
    int         words_checked;

    cdc_bridge_top #(.DEPTH(depth)) u_dut (
        .wr_clk     (wr_clk),
        .rd_clk     (rd_clk),
        .rd_reset   (rd_reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .word_data  (word_data),
        .word_valid (word_valid),
        .word_ready (word_ready)
    );

    always #(wr_period / 2) wr_clk = ~wr_clk;
    always #(rd_half) rd_clk = ~rd_clk;

    // Ready stays low in mode 0, high in mode 1 and random otherwise
    always @(posedge rd_clk) begin
        case (ready_mode)
            0: word_ready <= 1'b0;
            1: word_ready <= 1'b1;
            default: word_ready <= 1'($urandom_range(0, 1));
        endcase
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Word accepted at the next rd_clk edge is compared with four model bytes
    always @(negedge rd_clk) begin : word_monitor
        logic [31:0] exp_word;
        if (!rd_reset && word_valid && word_ready) begin
            if (model_q.size() < 4) begin
                $display("Word accepted at %0t before four bytes were written", $time);
                errors++;
            end else begin
                exp_word = {model_q[3], model_q[2], model_q[1], model_q[0]};
                repeat (4) void'(model_q.pop_front());
                check_val("word_data", exp_word, word_data);
                words_checked++;
            end
        end
    end

    task automatic apb_xfer(input logic [addr_w-1:0] addr, input logic wr,
                            input logic [31:0] wdata, input int stall,
                            output logic [31:0] rdata, output logic err);
        int   waits;
        int   i;
        logic exp_err;
        waits   = 0;
        exp_err = !((addr == reg_data && wr) || (addr == reg_status && !wr));
        @(posedge wr_clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge wr_clk);
        penable <= 1'b1;
        @(negedge wr_clk);
        // Cycles in which the write must still be held off
        for (i = 0; i < stall; i++) begin
            check_val("pready", 0, pready);
            @(negedge wr_clk);
        end
        while (!pready) begin
            waits++;
            @(negedge wr_clk);
        end
        rdata = prdata;
        err   = pslverr;
        if (wr && addr == reg_data) begin
            model_q.push_back(wdata[7:0]);
        end else begin
            check_val("wait_states", 0, waits);
        end
        check_val("pslverr", exp_err, err);
        @(posedge wr_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_bytes(input int count);
        logic [31:0] rdata;
        logic        err;
        repeat (count) apb_xfer(reg_data, 1'b1, $urandom, 0, rdata, err);
    endtask

    task automatic wait_drain();
        while (model_q.size() != 0) @(posedge wr_clk);
        repeat (4) @(posedge rd_clk);
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", name, errors - test_start_errors);
        end
    endtask

    // Hang guard scaled to the planned number of transfers
    initial begin
        #(planned_xfers * 40 * wr_period);
        $display("Watchdog expired at %0t, the bridge stopped making progress", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int          i;
        int          k;
        int          exp_level;
        logic [31:0] rdata;
        logic        err;
        logic [3:0]  other;
        void'($urandom(32'ha47a_4d6f));
        rd_reset   = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        word_ready = 1'b0;
        ready_mode = 0;
        errors     = 0;
        repeat (5) @(posedge wr_clk);
        rd_reset <= 1'b0;

        start_test();
        @(negedge wr_clk);
        check_val("word_valid", 0, word_valid);
        check_val("pready", 1, pready);
        apb_xfer(reg_status, 1'b0, 32'h0, 0, rdata, err);
        check_val("status.full", 0, rdata[0]);
        check_val("status.level", 0, rdata[8 +: lvl_bits]);
        end_test("reset_state");

        start_test();
        ready_mode = 2;
        for (i = 0; i < 200; i++) begin
            repeat ($urandom_range(0, 3)) @(posedge wr_clk);
            apb_xfer(reg_data, 1'b1, $urandom, 0, rdata, err);
        end
        wait_drain();
        end_test("order_and_packing");

        start_test();
        ready_mode = 0;
        k = $urandom_range(1, depth);
        write_bytes(k);
        repeat (10) @(posedge wr_clk);
        exp_level = k - ((k < 4) ? k : 4);
        apb_xfer(reg_status, 1'b0, 32'h0, 0, rdata, err);
        check_val("status.level", exp_level, rdata[8 +: lvl_bits]);
        check_val("status.full", exp_level == depth, rdata[0]);
        // Complete the last word so the packer starts the next test empty
        write_bytes((4 - k % 4) % 4);
        ready_mode = 1;
        wait_drain();
        end_test("level_count");

        start_test();
        ready_mode = 0;
        write_bytes(20);
        apb_xfer(reg_status, 1'b0, 32'h0, 0, rdata, err);
        check_val("status.full", 1, rdata[0]);
        check_val("status.level", depth, rdata[8 +: lvl_bits]);
        fork
            apb_xfer(reg_data, 1'b1, $urandom, 8, rdata, err);
            begin
                repeat (12) @(posedge wr_clk);
                ready_mode = 1;
            end
        join
        write_bytes(3);
        wait_drain();
        end_test("full_backpressure");

        start_test();
        other = 4'(4 * $urandom_range(2, 3));
        apb_xfer(reg_data, 1'b0, 32'h0, 0, rdata, err);
        apb_xfer(reg_status, 1'b1, $urandom, 0, rdata, err);
        apb_xfer(other, 1'b1, $urandom, 0, rdata, err);
        // A stray push from a bad access would shift these bytes
        write_bytes(4);
        wait_drain();
        end_test("error_responses");

        $display("Summary: %0d tests, %0d failed, %0d words checked, %0d errors",
                 tests_run, tests_failed, words_checked, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
src/cdc_pkg.sv
src/gray_sync.sv
src/async_fifo.sv
src/apb_fifo_port.sv
src/word_packer.sv
src/cdc_bridge_top.sv
verif/tb_cdc_bridge.sv

/* Bender.yml */
package:
  name: cdc_bridge

sources:
  - files:
      - src/cdc_pkg.sv
      - src/gray_sync.sv
      - src/async_fifo.sv
      - src/apb_fifo_port.sv
      - src/word_packer.sv
      - src/cdc_bridge_top.sv

  - target: test
    files:
      - verif/tb_cdc_bridge.sv
